//--- logic/mldsa_params_pkg.sv
/*
 * ML-DSA arithmetic constants for the z signature encoder:
 * ring size, modulus, coefficient width, GAMMA1 and encoded width.
 */

package mldsa_params_pkg;

    // ========================================
    // Ring and modulus
    // ========================================

    // Coefficients in one polynomial
    localparam int unsigned MLDSA_N = 256;

    // Prime modulus q = 2^23 - 2^13 + 1
    localparam int unsigned MLDSA_Q = 8380417;

    // Stored coefficient width in the source memory
    localparam int unsigned COEFF_W = 24;

    // ========================================
    // z encoding
    // ========================================

    // GAMMA1 = 2^19, the only parameter set handled here
    localparam int unsigned GAMMA1_VAL = 1 << 19;

    // Each encoded z coefficient packs into 20 bits
    localparam int unsigned ENC_W = 20;

endpackage

//--- logic/sigenc_z_defs_pkg.sv
/*
 * Structure constants of the z encoder: address and word widths,
 * read and pair counts, credit sizing and the controller state codes.
 */

package sigenc_z_defs_pkg;

    // ========================================
    // Datapath sizing
    // ========================================

    localparam int unsigned MEM_ADDR_W      = 14;
    localparam int unsigned COEFFS_PER_READ = 4;

    // Each pair of reads covers eight coefficients
    localparam int unsigned NUM_READ_PAIRS = mldsa_params_pkg::MLDSA_N / 8;

    localparam int unsigned LANE_W     = COEFFS_PER_READ * mldsa_params_pkg::ENC_W;
    localparam int unsigned SIG_WORD_W = 2 * LANE_W;

    // ========================================
    // Flow control and counters
    // ========================================

    localparam int unsigned CREDIT_W   = 3;
    localparam int unsigned PAIR_CNT_W = 6;

    // Words the sink can hold before it must return a credit
    localparam logic [CREDIT_W-1:0] SIG_CREDITS = 3'd4;

    // Controller states
    localparam int unsigned STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE  = 2'd0;
    localparam logic [STATE_W-1:0] ST_RUN   = 2'd1;
    localparam logic [STATE_W-1:0] ST_DRAIN = 2'd2;
    localparam logic [STATE_W-1:0] ST_DONE  = 2'd3;

endpackage

//--- logic/z_encode_lane.sv
/*
 * One encode lane: four z coefficients mapped to GAMMA1 - z (mod q)
 * in parallel, registered once together with their valid bit.
 */

`timescale 1ns/1ps

module z_encode_lane (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic in_valid,
    input  logic [sigenc_z_defs_pkg::COEFFS_PER_READ-1:0][mldsa_params_pkg::COEFF_W-1:0] coeffs,
    output logic out_valid,
    output logic [sigenc_z_defs_pkg::LANE_W-1:0] enc
);

    localparam int unsigned CW    = mldsa_params_pkg::COEFF_W;
    localparam int unsigned ENC_W = mldsa_params_pkg::ENC_W;

    // One spare bit keeps GAMMA1 + q - z from overflowing
    localparam logic [CW:0] GAMMA1_X = (CW+1)'(mldsa_params_pkg::GAMMA1_VAL);
    localparam logic [CW:0] Q_X      = (CW+1)'(mldsa_params_pkg::MLDSA_Q);

    logic [sigenc_z_defs_pkg::LANE_W-1:0] enc_next;

    for (genvar i = 0; i < sigenc_z_defs_pkg::COEFFS_PER_READ; i++) begin : g_coeff
        logic [CW:0] z_ext;
        logic [CW:0] z_diff;

        assign z_ext = {1'b0, coeffs[i]};

        // Small z maps directly, larger z is treated as the negative value z - q
        always_comb begin
            if (z_ext <= GAMMA1_X) begin
                z_diff = GAMMA1_X - z_ext;
            end else begin
                z_diff = GAMMA1_X + Q_X - z_ext;
            end
        end

        // Coefficient i lands in bits [20i +: 20], coefficient 0 lowest
        assign enc_next[i*ENC_W +: ENC_W] = z_diff[ENC_W-1:0];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (zeroize) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            enc <= enc_next;
        end
    end

endmodule

//--- logic/sig_word_packer.sv
/*
 * Signature word packer: joins the two encode lanes into one 160-bit
 * word and writes it to dest_base + k, one word per lane pair.
 */

`timescale 1ns/1ps

module sig_word_packer (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic start,
    input  logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] dest_base_addr,
    input  logic a_valid,
    input  logic [sigenc_z_defs_pkg::LANE_W-1:0] a_enc,
    input  logic b_valid,
    input  logic [sigenc_z_defs_pkg::LANE_W-1:0] b_enc,
    output logic sig_wr_valid,
    output logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] sig_wr_addr,
    output logic [sigenc_z_defs_pkg::SIG_WORD_W-1:0] sig_wr_data
);

    localparam int unsigned ADDR_W = sigenc_z_defs_pkg::MEM_ADDR_W;

    logic [ADDR_W-1:0] dest_base;
    logic [sigenc_z_defs_pkg::PAIR_CNT_W-1:0] word_idx;
    logic both_valid;

    // Both lanes come from the same read cycle, so they always line up
    assign both_valid = a_valid && b_valid;

    // ========================================
    // Word counter and write strobe
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            word_idx     <= '0;
            sig_wr_valid <= 1'b0;
        end else if (zeroize) begin
            word_idx     <= '0;
            sig_wr_valid <= 1'b0;
        end else begin
            sig_wr_valid <= both_valid;
            if (start) begin
                word_idx <= '0;
            end else if (both_valid) begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    // ========================================
    // Destination base, address and data
    // ========================================

    always_ff @(posedge clk) begin
        if (start) begin
            dest_base <= dest_base_addr;
        end
    end

    // Lane a fills the low half of the word, lane b the high half
    always_ff @(posedge clk) begin
        if (both_valid) begin
            sig_wr_addr <= dest_base + ADDR_W'(word_idx);
            sig_wr_data <= {b_enc, a_enc};
        end
    end

endmodule

//--- logic/sigenc_z_ctrl.sv
/*
 * Run controller of the z encoder: idle/run/drain/done FSM, paired
 * source address generation, sink credit counter, word counting and
 * the done pulse.
 */

`timescale 1ns/1ps

module sigenc_z_ctrl (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic enable,
    input  logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] src_base_addr,
    input  logic sig_credit_return,
    input  logic sig_wr_valid,
    output logic start,
    output logic mem_rd_en,
    output logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] mem_a_addr,
    output logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] mem_b_addr,
    output logic lane_in_valid,
    output logic done
);

    localparam int unsigned ADDR_W = sigenc_z_defs_pkg::MEM_ADDR_W;
    localparam int unsigned CNT_W  = sigenc_z_defs_pkg::PAIR_CNT_W;
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(sigenc_z_defs_pkg::NUM_READ_PAIRS - 1);

    logic [sigenc_z_defs_pkg::STATE_W-1:0] state;
    logic [sigenc_z_defs_pkg::STATE_W-1:0] next_state;
    logic [ADDR_W-1:0] src_base;
    logic [CNT_W-1:0] pair_cnt;
    logic [CNT_W-1:0] word_cnt;
    logic [sigenc_z_defs_pkg::CREDIT_W-1:0] credit_cnt;
    logic issue;
    logic last_pair;
    logic last_word;

    assign start = (state == sigenc_z_defs_pkg::ST_IDLE) && enable && !zeroize;

    // A pair read needs one credit in hand
    assign issue = (state == sigenc_z_defs_pkg::ST_RUN) && (credit_cnt != '0) && !zeroize;

    assign last_pair = (pair_cnt == LAST_IDX);
    assign last_word = sig_wr_valid && (word_cnt == LAST_IDX);

    // ========================================
    // State machine
    // ========================================

    always_comb begin
        next_state = state;
        case (state)
            sigenc_z_defs_pkg::ST_IDLE: begin
                if (start) begin
                    next_state = sigenc_z_defs_pkg::ST_RUN;
                end
            end
            sigenc_z_defs_pkg::ST_RUN: begin
                if (issue && last_pair) begin
                    next_state = sigenc_z_defs_pkg::ST_DRAIN;
                end
            end
            sigenc_z_defs_pkg::ST_DRAIN: begin
                // Words still in flight were already paid for, so this always ends
                if (last_word) begin
                    next_state = sigenc_z_defs_pkg::ST_DONE;
                end
            end
            default: begin
                next_state = sigenc_z_defs_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= sigenc_z_defs_pkg::ST_IDLE;
        end else if (zeroize) begin
            state <= sigenc_z_defs_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign done = (state == sigenc_z_defs_pkg::ST_DONE);

    // ========================================
    // Counters and credit tracking
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pair_cnt      <= '0;
            word_cnt      <= '0;
            credit_cnt    <= sigenc_z_defs_pkg::SIG_CREDITS;
            lane_in_valid <= 1'b0;
        end else if (zeroize) begin
            pair_cnt      <= '0;
            word_cnt      <= '0;
            credit_cnt    <= sigenc_z_defs_pkg::SIG_CREDITS;
            lane_in_valid <= 1'b0;
        end else begin
            // Read data comes back one cycle after the request
            lane_in_valid <= issue;

            if (start) begin
                pair_cnt <= '0;
            end else if (issue) begin
                pair_cnt <= pair_cnt + 1'b1;
            end

            if (start) begin
                word_cnt <= '0;
            end else if (sig_wr_valid) begin
                word_cnt <= word_cnt + 1'b1;
            end

            // Late returns after a zeroize never push the count past its limit
            if (issue && !sig_credit_return) begin
                credit_cnt <= credit_cnt - 1'b1;
            end else if (!issue && sig_credit_return &&
                         credit_cnt != sigenc_z_defs_pkg::SIG_CREDITS) begin
                credit_cnt <= credit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            src_base <= src_base_addr;
        end
    end

    // Port a reads base + 2k, port b the next address
    assign mem_rd_en  = issue;
    assign mem_a_addr = src_base + ADDR_W'({pair_cnt, 1'b0});
    assign mem_b_addr = mem_a_addr + 1'b1;

endmodule

//--- logic/sigenc_z_top.sv
/*
 * Top level of the z signature encoder: controller, the two encode
 * lanes on memory ports a and b, and the signature word packer.
 */

`timescale 1ns/1ps

module sigenc_z_top (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic enable,
    output logic done,
    input  logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] src_base_addr,
    input  logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] dest_base_addr,
    output logic mem_rd_en,
    output logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] mem_a_addr,
    output logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] mem_b_addr,
    input  logic [sigenc_z_defs_pkg::COEFFS_PER_READ-1:0][mldsa_params_pkg::COEFF_W-1:0] mem_a_data,
    input  logic [sigenc_z_defs_pkg::COEFFS_PER_READ-1:0][mldsa_params_pkg::COEFF_W-1:0] mem_b_data,
    output logic sig_wr_valid,
    output logic [sigenc_z_defs_pkg::MEM_ADDR_W-1:0] sig_wr_addr,
    output logic [sigenc_z_defs_pkg::SIG_WORD_W-1:0] sig_wr_data,
    input  logic sig_credit_return
);

    logic start;
    logic lane_in_valid;
    logic a_valid;
    logic b_valid;
    logic [sigenc_z_defs_pkg::LANE_W-1:0] a_enc;
    logic [sigenc_z_defs_pkg::LANE_W-1:0] b_enc;

    sigenc_z_ctrl ctrl_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .enable            (enable),
        .src_base_addr     (src_base_addr),
        .sig_credit_return (sig_credit_return),
        .sig_wr_valid      (sig_wr_valid),
        .start             (start),
        .mem_rd_en         (mem_rd_en),
        .mem_a_addr        (mem_a_addr),
        .mem_b_addr        (mem_b_addr),
        .lane_in_valid     (lane_in_valid),
        .done              (done)
    );

    // Both lanes see the same valid, one per memory read port
    z_encode_lane lane_a (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (lane_in_valid),
        .coeffs    (mem_a_data),
        .out_valid (a_valid),
        .enc       (a_enc)
    );

    z_encode_lane lane_b (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (lane_in_valid),
        .coeffs    (mem_b_data),
        .out_valid (b_valid),
        .enc       (b_enc)
    );

    sig_word_packer packer_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .start          (start),
        .dest_base_addr (dest_base_addr),
        .a_valid        (a_valid),
        .a_enc          (a_enc),
        .b_valid        (b_valid),
        .b_enc          (b_enc),
        .sig_wr_valid   (sig_wr_valid),
        .sig_wr_addr    (sig_wr_addr),
        .sig_wr_data    (sig_wr_data)
    );

endmodule

//--- dv/sigenc_z_tb.sv
/*
 * Testbench for the z signature encoder: clock and reset, source memory
 * model, credit-returning sink, reference encoder model, address, latency,
 * credit and completion checks, zeroize run and cycle-limit watchdog.
 */

`timescale 1ns/1ps

module sigenc_z_tb;

    localparam int unsigned ADDR_W      = sigenc_z_defs_pkg::MEM_ADDR_W;
    localparam int unsigned CPR         = sigenc_z_defs_pkg::COEFFS_PER_READ;
    localparam int unsigned CW          = mldsa_params_pkg::COEFF_W;
    localparam int unsigned ENC_W       = mldsa_params_pkg::ENC_W;
    localparam int unsigned LANE_W      = sigenc_z_defs_pkg::LANE_W;
    localparam int unsigned WORD_W      = sigenc_z_defs_pkg::SIG_WORD_W;
    localparam int unsigned PAIRS       = sigenc_z_defs_pkg::NUM_READ_PAIRS;
    localparam int unsigned NUM_RUNS    = 4;
    localparam int unsigned RUN_CYCLES  = 400;
    localparam int unsigned CYCLE_LIMIT = NUM_RUNS * RUN_CYCLES;
    localparam int unsigned HOLD_CYCLES = 30;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic enable;
    logic done;
    logic [ADDR_W-1:0] src_base_addr;
    logic [ADDR_W-1:0] dest_base_addr;
    logic mem_rd_en;
    logic [ADDR_W-1:0] mem_a_addr;
    logic [ADDR_W-1:0] mem_b_addr;
    logic [CPR-1:0][CW-1:0] mem_a_data;
    logic [CPR-1:0][CW-1:0] mem_b_data;
    logic sig_wr_valid;
    logic [ADDR_W-1:0] sig_wr_addr;
    logic [WORD_W-1:0] sig_wr_data;
    logic sig_credit_return;

    logic [CPR*CW-1:0] src_mem [0:(1<<ADDR_W)-1];
    logic [31:0] rng;
    logic [ADDR_W-1:0] src_base;
    logic [ADDR_W-1:0] dest_base;
    logic rd_pending;
    logic [ADDR_W-1:0] rd_a_addr;
    logic [ADDR_W-1:0] rd_b_addr;
    logic random_returns;
    logic withhold;
    int cycle;
    int reads_seen;
    int writes_seen;
    int done_seen;
    int writes_since_ret;
    int last_write_cycle;
    int check_count;
    int error_count;
    int rd_cycle_q[$];
    int ret_due_q[$];

    sigenc_z_top sigenc_z_top_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .enable            (enable),
        .done              (done),
        .src_base_addr     (src_base_addr),
        .dest_base_addr    (dest_base_addr),
        .mem_rd_en         (mem_rd_en),
        .mem_a_addr        (mem_a_addr),
        .mem_b_addr        (mem_b_addr),
        .mem_a_data        (mem_a_data),
        .mem_b_data        (mem_b_data),
        .sig_wr_valid      (sig_wr_valid),
        .sig_wr_addr       (sig_wr_addr),
        .sig_wr_data       (sig_wr_data),
        .sig_credit_return (sig_credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Helpers and reference model
    // ========================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Values at or below GAMMA1 map to GAMMA1 - z, the rest to GAMMA1 - z + q
    function automatic logic [ENC_W-1:0] encode_coeff(input logic [CW-1:0] z);
        logic [31:0] v;
        if (z <= mldsa_params_pkg::GAMMA1_VAL) begin
            v = mldsa_params_pkg::GAMMA1_VAL - z;
        end else begin
            v = mldsa_params_pkg::GAMMA1_VAL + mldsa_params_pkg::MLDSA_Q - z;
        end
        return v[ENC_W-1:0];
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input int k);
        logic [ADDR_W-1:0] addr_a;
        logic [CPR*CW-1:0] word_a;
        logic [CPR*CW-1:0] word_b;
        logic [WORD_W-1:0] w;
        addr_a = src_base + ADDR_W'(2 * k);
        word_a = src_mem[addr_a];
        word_b = src_mem[addr_a + 1'b1];
        for (int i = 0; i < CPR; i++) begin
            w[i*ENC_W +: ENC_W] = encode_coeff(word_a[i*CW +: CW]);
            w[LANE_W + i*ENC_W +: ENC_W] = encode_coeff(word_b[i*CW +: CW]);
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic clear_tracking();
        reads_seen = 0;
        writes_seen = 0;
        done_seen = 0;
        writes_since_ret = 0;
        last_write_cycle = 0;
        rd_cycle_q.delete();
        ret_due_q.delete();
    endtask

    // ========================================
    // Monitor, sink and memory model
    // ========================================

    // Outputs are sampled at the falling edge, where they have settled
    always @(negedge clk) begin
        if (reset_n) begin
            rd_pending = mem_rd_en;
            rd_a_addr = mem_a_addr;
            rd_b_addr = mem_b_addr;
            if (mem_rd_en) begin
                check_value("mem_a_addr", mem_a_addr, ADDR_W'(src_base + 2 * reads_seen));
                check_value("mem_b_addr", mem_b_addr, ADDR_W'(src_base + 2 * reads_seen + 1));
                rd_cycle_q.push_back(cycle);
                reads_seen++;
            end
            if (sig_credit_return) begin
                writes_since_ret = 0;
            end
            if (sig_wr_valid) begin
                check_value("sig_wr_addr", sig_wr_addr, ADDR_W'(dest_base + writes_seen));
                check_value("sig_wr_data", sig_wr_data, expected_word(writes_seen));
                if (rd_cycle_q.size() > 0) begin
                    check_value("sig_wr_latency", cycle - rd_cycle_q.pop_front(), 3);
                end else begin
                    error_count++;
                    $display("Error at t=%0t: a word was written with no read outstanding",
                             $time);
                end
                writes_seen++;
                writes_since_ret++;
                last_write_cycle = cycle;
                check_value("words_without_credit",
                            writes_since_ret > sigenc_z_defs_pkg::SIG_CREDITS, 0);
                rng = xorshift32(rng);
                ret_due_q.push_back(cycle + 1 + (random_returns ? int'(rng % 6) : 0));
            end
            if (done) begin
                done_seen++;
                check_value("done_cycle", cycle, last_write_cycle + 1);
                check_value("words_at_done", writes_seen, PAIRS);
            end
            // The sink is cleared together with the encoder
            if (zeroize) begin
                clear_tracking();
            end
        end
    end

    always @(posedge clk) begin : drive_sink_and_mem
        #1;
        sig_credit_return = 1'b0;
        if (!withhold && ret_due_q.size() > 0) begin
            if (ret_due_q[0] <= cycle) begin
                void'(ret_due_q.pop_front());
                sig_credit_return = 1'b1;
            end
        end
        if (rd_pending) begin
            mem_a_data = src_mem[rd_a_addr];
            mem_b_data = src_mem[rd_b_addr];
        end
    end

    // ========================================
    // Run control
    // ========================================

    task automatic start_run(input logic random_ret);
        @(posedge clk);
        #1;
        rng = xorshift32(rng);
        src_base = rng[ADDR_W-1:0];
        rng = xorshift32(rng);
        dest_base = rng[ADDR_W-1:0];
        // Corner values sit in the first read of every run
        src_mem[src_base] = {CW'(mldsa_params_pkg::MLDSA_Q - 1),
                             CW'(mldsa_params_pkg::GAMMA1_VAL + 1),
                             CW'(mldsa_params_pkg::GAMMA1_VAL), CW'(0)};
        random_returns = random_ret;
        clear_tracking();
        src_base_addr = src_base;
        dest_base_addr = dest_base;
        enable = 1'b1;
        @(posedge clk);
        #1;
        enable = 1'b0;
    endtask

    task automatic finish_run();
        while (done_seen == 0) @(posedge clk);
        repeat (8) @(posedge clk);
        while (ret_due_q.size() > 0) @(posedge clk);
        check_value("mem_rd_en_count", reads_seen, PAIRS);
        check_value("sig_wr_valid_count", writes_seen, PAIRS);
        check_value("done_count", done_seen, 1);
    endtask

    initial begin
        cycle = 0;
        while (cycle < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset_n = 1'b0;
        zeroize = 1'b0;
        enable = 1'b0;
        src_base_addr = '0;
        dest_base_addr = '0;
        mem_a_data = '0;
        mem_b_data = '0;
        sig_credit_return = 1'b0;
        rd_pending = 1'b0;
        random_returns = 1'b0;
        withhold = 1'b0;
        src_base = '0;
        dest_base = '0;
        check_count = 0;
        error_count = 0;
        clear_tracking();
        rng = 32'd96614;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            for (int i = 0; i < CPR; i++) begin
                rng = xorshift32(rng);
                src_mem[a][i*CW +: CW] = rng % mldsa_params_pkg::MLDSA_Q;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Immediate credit returns
        start_run(1'b0);
        finish_run();

        // Returns held back at first, so only the initial credits can be spent
        withhold = 1'b1;
        start_run(1'b1);
        repeat (HOLD_CYCLES) @(posedge clk);
        check_value("words_while_withheld", writes_seen, sigenc_z_defs_pkg::SIG_CREDITS);
        withhold = 1'b0;
        finish_run();

        // Zeroize in the middle of a run with random return delays
        start_run(1'b1);
        while (writes_seen < 10) @(posedge clk);
        #1;
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("mem_rd_en", mem_rd_en, 0);
            check_value("sig_wr_valid", sig_wr_valid, 0);
            check_value("done", done, 0);
        end

        start_run(1'b1);
        finish_run();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sigenc_z_top.f
logic/mldsa_params_pkg.sv
logic/sigenc_z_defs_pkg.sv
logic/z_encode_lane.sv
logic/sig_word_packer.sv
logic/sigenc_z_ctrl.sv
logic/sigenc_z_top.sv
dv/sigenc_z_tb.sv
